/* verilog/rob_defines.svh */
`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

// buffer geometry
`define ROB_SIZE 16
`define ROB_IDX_W 4

// per-cycle bandwidth
`define DISP_W 2
`define RET_W 2
`define WB_PORTS 2

// payload fields
`define AREG_W 5
`define PREG_W 6

// zero code means no exception
`define EXC_W 4

`endif

/* verilog/robEntryPkg.sv */
`default_nettype none
`include "rob_defines.svh"

package robEntryPkg;

    // slot position in the ring
    typedef logic [`ROB_IDX_W-1:0] robIdxT;

    // 0 .. ROB_SIZE, one bit wider than an index
    typedef logic [`ROB_IDX_W:0] robCountT;

    typedef logic [`AREG_W-1:0] aregT;
    typedef logic [`PREG_W-1:0] pregT;

    // what dispatch hands over and retire hands back
    typedef struct packed {
        logic we;
        aregT areg;
        pregT preg;
    } robEntryT;

endpackage

`default_nettype wire

/* verilog/robEventPkg.sv */
`default_nettype none
`include "rob_defines.svh"

package robEventPkg;

    typedef logic [`EXC_W-1:0] excCodeT;

    // 0 .. RET_W entries per cycle
    typedef logic [1:0] retireNumT;

    // retFlush covers the cycle of the exception report
    typedef enum logic {
        retRun,
        retFlush
    } retireStateT;

endpackage

`default_nettype wire

/* verilog/robIfs.sv */
`default_nettype none
`include "rob_defines.svh"

interface robHeadIf;
    import robEntryPkg::*;
    import robEventPkg::*;

    // pointer state
    robIdxT headIdx;
    robCountT count;
    robIdxT tail;

    // combinational view of the head slots
    robEntryT [`RET_W-1:0] headEntry;
    logic [`RET_W-1:0] headDone;
    excCodeT [`RET_W-1:0] headExc;

    // retire decision back to the pointers
    retireNumT retireNum;
    logic flush;

    modport ptr (
        output headIdx, count, tail,
        input retireNum, flush
    );

    modport ram (
        input headIdx,
        output headEntry
    );

    modport status (
        input headIdx, count, tail,
        output headDone, headExc
    );

    modport retire (
        input headIdx, count, headEntry, headDone, headExc,
        output retireNum, flush
    );

endinterface

`default_nettype wire

/* verilog/robPointers.sv */
`default_nettype none
`include "rob_defines.svh"

module robPointers (
    input wire logic clk,
    input wire logic rst,
    input wire logic [`DISP_W-1:0] dispEn,
    output logic full,
    output robEntryPkg::robIdxT allocIdx,
    output logic [`DISP_W-1:0] allocEn,
    robHeadIf.ptr head
);
    import robEntryPkg::*;

    robIdxT headPtr;
    robIdxT tailPtr;
    robCountT count;
    robCountT freeCount;
    robCountT accNum;
    robCountT retNum;

    assign freeCount = robCountT'(`ROB_SIZE) - count;

    // no dispatch while an exception is being taken
    assign full = (freeCount < robCountT'(`DISP_W)) | head.flush;

    assign allocEn = dispEn & {`DISP_W{~full}};
    assign allocIdx = tailPtr;
    assign retNum = robCountT'(head.retireNum);

    // enables are contiguous, so a plain sum
    always_comb begin
        accNum = '0;
        for (int i = 0; i < `DISP_W; i++) begin
            accNum = accNum + robCountT'(allocEn[i]);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else if (head.flush) begin
            // drop everything in flight
            headPtr <= tailPtr;
            count <= '0;
        end else begin
            headPtr <= headPtr + robIdxT'(head.retireNum);
            tailPtr <= tailPtr + robIdxT'(accNum);
            count <= count + accNum - retNum;
        end
    end

    assign head.headIdx = headPtr;
    assign head.count = count;
    assign head.tail = tailPtr;

endmodule

`default_nettype wire

/* verilog/robEntryRam.sv */
`default_nettype none
`include "rob_defines.svh"

module robEntryRam (
    input wire logic clk,
    input wire logic [`DISP_W-1:0] allocEn,
    input wire robEntryPkg::robIdxT allocIdx,
    input wire robEntryPkg::robEntryT [`DISP_W-1:0] dispEntry,
    robHeadIf.ram head
);
    import robEntryPkg::*;

    robEntryT mem [`ROB_SIZE];

    // slot i lands i entries past the tail
    always_ff @(posedge clk) begin
        for (int i = 0; i < `DISP_W; i++) begin
            if (allocEn[i]) begin
                mem[robIdxT'(allocIdx + i)] <= dispEntry[i];
            end
        end
    end

    // head and the ones behind it, wrapping
    always_comb begin
        for (int r = 0; r < `RET_W; r++) begin
            head.headEntry[r] = mem[robIdxT'(head.headIdx + r)];
        end
    end

endmodule

`default_nettype wire

/* verilog/robStatus.sv */
`default_nettype none
`include "rob_defines.svh"

module robStatus (
    input wire logic clk,
    input wire logic rst,
    input wire logic [`DISP_W-1:0] allocEn,
    input wire robEntryPkg::robIdxT allocIdx,
    input wire logic [`WB_PORTS-1:0] wbEn,
    input wire robEntryPkg::robIdxT [`WB_PORTS-1:0] wbIdx,
    input wire robEventPkg::excCodeT [`WB_PORTS-1:0] wbExc,
    robHeadIf.status head
);
    import robEntryPkg::*;
    import robEventPkg::*;

    logic [`ROB_SIZE-1:0] done;
    excCodeT codes [`ROB_SIZE];
    logic [`WB_PORTS-1:0] wbHit;
    robIdxT span;

    // live window is head up to tail, or the whole ring when count is full
    assign span = head.tail - head.headIdx;

    always_comb begin
        for (int p = 0; p < `WB_PORTS; p++) begin
            // first writeback to a live entry only
            wbHit[p] = wbEn[p] && !done[wbIdx[p]] &&
                       (head.count[`ROB_IDX_W] ||
                        (robIdxT'(wbIdx[p] - head.headIdx) < span));
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done <= '0;
        end else begin
            for (int p = 0; p < `WB_PORTS; p++) begin
                if (wbHit[p]) begin
                    done[wbIdx[p]] <= 1'b1;
                end
            end
            // fresh slots start pending
            for (int i = 0; i < `DISP_W; i++) begin
                if (allocEn[i]) begin
                    done[robIdxT'(allocIdx + i)] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < `WB_PORTS; p++) begin
            if (wbHit[p]) begin
                codes[wbIdx[p]] <= wbExc[p];
            end
        end
    end

    always_comb begin
        for (int r = 0; r < `RET_W; r++) begin
            head.headDone[r] = done[robIdxT'(head.headIdx + r)];
            head.headExc[r] = codes[robIdxT'(head.headIdx + r)];
        end
    end

endmodule

`default_nettype wire

/* verilog/robRetire.sv */
`default_nettype none
`include "rob_defines.svh"

module robRetire (
    input wire logic clk,
    input wire logic rst,
    robHeadIf.retire head,
    output logic [`RET_W-1:0] retValid,
    output logic [`RET_W-1:0] retWe,
    output robEntryPkg::aregT [`RET_W-1:0] retAreg,
    output robEntryPkg::pregT [`RET_W-1:0] retPreg,
    output robEntryPkg::robIdxT retHeadIdx,
    output logic excValid,
    output robEntryPkg::robIdxT excIdx,
    output robEventPkg::excCodeT excCode
);
    import robEntryPkg::*;
    import robEventPkg::*;

    retireStateT state;
    retireStateT stateNext;
    logic [`RET_W-1:0] slotOk;
    retireNumT retNum;
    logic takeExc;

    // a slot retires only if every older head slot does
    always_comb begin
        logic chain;
        chain = (state == retRun);
        for (int i = 0; i < `RET_W; i++) begin
            chain = chain && (head.count > robCountT'(i)) && head.headDone[i] &&
                    (head.headExc[i] == '0);
            slotOk[i] = chain;
        end
    end

    always_comb begin
        retNum = '0;
        for (int i = 0; i < `RET_W; i++) begin
            retNum = retNum + retireNumT'(slotOk[i]);
        end
    end

    // faulting entry at the head, later slots wait until they get there
    assign takeExc = (state == retRun) && (head.count != '0) && head.headDone[0] &&
                     (head.headExc[0] != '0);

    assign head.retireNum = retNum;
    assign head.flush = takeExc;

    always_comb begin
        case (state)
            retRun: stateNext = takeExc ? retFlush : retRun;
            retFlush: stateNext = retRun;
            default: stateNext = retRun;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= retRun;
            retValid <= '0;
            retWe <= '0;
            excValid <= 1'b0;
        end else begin
            state <= stateNext;
            retValid <= slotOk;
            excValid <= takeExc;
            for (int i = 0; i < `RET_W; i++) begin
                retWe[i] <= slotOk[i] & head.headEntry[i].we;
            end
        end
    end

    // payload, only meaningful alongside the valids
    always_ff @(posedge clk) begin
        retHeadIdx <= head.headIdx;
        excIdx <= head.headIdx;
        excCode <= head.headExc[0];
        for (int i = 0; i < `RET_W; i++) begin
            retAreg[i] <= head.headEntry[i].areg;
            retPreg[i] <= head.headEntry[i].preg;
        end
    end

endmodule

`default_nettype wire

/* verilog/robTop.sv */
`default_nettype none
`include "rob_defines.svh"

module robTop (
    input wire logic clk,
    input wire logic rst,
    input wire logic [`DISP_W-1:0] dispEn,
    input wire robEntryPkg::robEntryT [`DISP_W-1:0] dispEntry,
    input wire logic [`WB_PORTS-1:0] wbEn,
    input wire robEntryPkg::robIdxT [`WB_PORTS-1:0] wbIdx,
    input wire robEventPkg::excCodeT [`WB_PORTS-1:0] wbExc,
    output logic full,
    output robEntryPkg::robIdxT allocIdx,
    output logic [`RET_W-1:0] retValid,
    output logic [`RET_W-1:0] retWe,
    output robEntryPkg::aregT [`RET_W-1:0] retAreg,
    output robEntryPkg::pregT [`RET_W-1:0] retPreg,
    output robEntryPkg::robIdxT retHeadIdx,
    output logic excValid,
    output robEntryPkg::robIdxT excIdx,
    output robEventPkg::excCodeT excCode
);

    // accepted dispatch slots
    logic [`DISP_W-1:0] allocEn;

    robHeadIf headBus ();

    robPointers uPointers (
        .clk(clk),
        .rst(rst),
        .dispEn(dispEn),
        .full(full),
        .allocIdx(allocIdx),
        .allocEn(allocEn),
        .head(headBus.ptr)
    );

    robEntryRam uEntryRam (
        .clk(clk),
        .allocEn(allocEn),
        .allocIdx(allocIdx),
        .dispEntry(dispEntry),
        .head(headBus.ram)
    );

    robStatus uStatus (
        .clk(clk),
        .rst(rst),
        .allocEn(allocEn),
        .allocIdx(allocIdx),
        .wbEn(wbEn),
        .wbIdx(wbIdx),
        .wbExc(wbExc),
        .head(headBus.status)
    );

    robRetire uRetire (
        .clk(clk),
        .rst(rst),
        .head(headBus.retire),
        .retValid(retValid),
        .retWe(retWe),
        .retAreg(retAreg),
        .retPreg(retPreg),
        .retHeadIdx(retHeadIdx),
        .excValid(excValid),
        .excIdx(excIdx),
        .excCode(excCode)
    );

endmodule

`default_nettype wire

/* test/robClock.sv */
`default_nettype none

module robClock (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // three cycles of reset
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

/* test/rob_assert.sv */
`default_nettype none
`include "rob_defines.svh"

module robAssert (
    input wire logic clk,
    input wire logic rst,
    input wire logic [`RET_W-1:0] retValid,
    input wire logic excValid
);
    timeunit 1ns;
    timeprecision 1ps;

    // retire slots fill from slot 0
    slotOrder: assert property (@(posedge clk) disable iff (rst)
        retValid[1] |-> retValid[0])
        else $error("retire slot 1 valid without slot 0");

    excPulse: assert property (@(posedge clk) disable iff (rst)
        excValid |=> !excValid)
        else $error("exception report longer than one cycle");

    excAlone: assert property (@(posedge clk) disable iff (rst)
        !(excValid && (|retValid)))
        else $error("exception report together with retirement");

endmodule

`default_nettype wire

/* test/robTb.sv */
`default_nettype none
`include "rob_defines.svh"

module robTb;
    timeunit 1ns;
    timeprecision 1ps;
    import robEntryPkg::*;
    import robEventPkg::*;

    logic clk, rst, full, excValid;
    logic [`DISP_W-1:0] dispEn;
    robEntryT [`DISP_W-1:0] dispEntry;
    logic [`WB_PORTS-1:0] wbEn;
    robIdxT [`WB_PORTS-1:0] wbIdx;
    excCodeT [`WB_PORTS-1:0] wbExc;
    robIdxT allocIdx, retHeadIdx, excIdx;
    logic [`RET_W-1:0] retValid, retWe;
    aregT [`RET_W-1:0] retAreg;
    pregT [`RET_W-1:0] retPreg;
    excCodeT excCode;

    // reference model state
    robEntryT mEnt [`ROB_SIZE];
    logic mDone [`ROB_SIZE] = '{default: 1'b0};
    excCodeT mCode [`ROB_SIZE];
    robIdxT mHead = '0;
    robIdxT mTail = '0;
    int mCount = 0;
    logic mFlush = 1'b0;
    logic [2:0] dec;
    logic expFull;
    logic [1:0] expValid = '0;
    logic expExc = 1'b0;
    robEntryT expEnt [`RET_W];
    robIdxT expHead, expExcIdx, expBase;
    excCodeT expExcCode;
    int excSeen = 0;
    int retired = 0;
    logic [31:0] rng = 32'h8602;

    robClock uClock (.clk(clk), .rst(rst));
    robTop UUT (.*);
    bind robTop robAssert uAssert (.clk(clk), .rst(rst), .retValid(retValid),
                                   .excValid(excValid));

    function automatic logic [31:0] nextRandom();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    task automatic stop(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkFlags(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) stop($sformatf("error: %s got %h expected %h", name, got, exp));
    endtask

    task automatic checkIndex(input string name, input robIdxT got, input robIdxT exp);
        if (got !== exp) stop($sformatf("error: %s got %h expected %h", name, got, exp));
    endtask

    task automatic checkRetire(input int slot, input robEntryT got, input robEntryT exp,
                               input robIdxT gotIdx, input robIdxT expIdx);
        if (got !== exp)
            stop($sformatf("error: {retWe, retAreg, retPreg}[%0d] got %h expected %h",
                           slot, got, exp));
        checkIndex("retHeadIdx", gotIdx, expIdx);
    endtask

    task automatic checkExc(input robIdxT gotIdx, input robIdxT expIdx,
                            input excCodeT gotCode, input excCodeT expCode);
        checkIndex("excIdx", gotIdx, expIdx);
        if (gotCode !== expCode)
            stop($sformatf("error: excCode got %h expected %h", gotCode, expCode));
    endtask

    // {exception, slot 1 retires, slot 0 retires} from the model state
    function automatic logic [2:0] refDecide();
        logic [1:0] ok;
        logic exc;
        robIdxT nxt;
        ok = '0;
        exc = 1'b0;
        nxt = mHead + 1'b1;
        if (!mFlush && mCount >= 1 && mDone[mHead]) begin
            ok[0] = (mCode[mHead] == '0);
            exc = (mCode[mHead] != '0);
            ok[1] = ok[0] && mCount >= 2 && mDone[nxt] && mCode[nxt] == '0;
        end
        return {exc, ok};
    endfunction

    // compare, then step the model across the coming edge
    always @(negedge clk) begin
        if (!rst) begin
            checkFlags("retValid", retValid, expValid);
            for (int i = 0; i < `RET_W; i++) begin
                if (expValid[i])
                    checkRetire(i, {retWe[i], retAreg[i], retPreg[i]}, expEnt[i],
                                retHeadIdx, expHead);
            end
            checkFlags("excValid", {1'b0, excValid}, {1'b0, expExc});
            if (expExc) begin
                checkExc(excIdx, expExcIdx, excCode, expExcCode);
                excSeen++;
            end
            retired += retValid[0] + retValid[1];
            dec = refDecide();
            expFull = (`ROB_SIZE - mCount < `DISP_W) || dec[2];
            checkFlags("full", {1'b0, full}, {1'b0, expFull});
            checkIndex("allocIdx", allocIdx, mTail);
            expValid = dec[1:0];
            for (int i = 0; i < `RET_W; i++) expEnt[i] = mEnt[robIdxT'(mHead + i)];
            expHead = mHead;
            expExc = dec[2];
            expExcIdx = mHead;
            expExcCode = mCode[mHead];
            for (int p = 0; p < `WB_PORTS; p++) begin
                if (wbEn[p]) begin
                    mDone[wbIdx[p]] = 1'b1;
                    mCode[wbIdx[p]] = wbExc[p];
                end
            end
            for (int i = 0; i < `DISP_W; i++) begin
                if (!expFull && dispEn[i]) begin
                    mEnt[mTail] = dispEntry[i];
                    mDone[mTail] = 1'b0;
                    mTail = mTail + 1'b1;
                    mCount++;
                end
            end
            if (dec[2]) begin
                mHead = mTail;
                mCount = 0;
            end else begin
                mHead = mHead + robIdxT'(dec[0]) + robIdxT'(dec[1]);
                mCount = mCount - dec[0] - dec[1];
            end
            mFlush = dec[2];
        end
    end

    // random payloads, writebacks picked out of order among pending entries
    task automatic driveRandom(input logic [1:0] en, input logic wbOn, input int excRate);
        robIdxT pend[$];
        logic [31:0] r;
        int k;
        @(posedge clk);
        for (int j = 0; j < mCount; j++) begin
            if (!mDone[robIdxT'(mHead + j)]) pend.push_back(robIdxT'(mHead + j));
        end
        r = nextRandom();
        dispEn <= en;
        dispEntry <= r[23:0];
        wbEn <= '0;
        for (int p = 0; p < `WB_PORTS; p++) begin
            if (wbOn && pend.size() > 0 && nextRandom() % 3 != 0) begin
                k = nextRandom() % pend.size();
                r = nextRandom();
                wbEn[p] <= 1'b1;
                wbIdx[p] <= pend[k];
                wbExc[p] <= (excRate > 0 && r % excRate == 0) ? excCodeT'(r[7:4] | 1) : '0;
                pend.delete(k);
            end
        end
    endtask

    task automatic driveFixed(input logic [1:0] en, input logic [1:0] wb,
                              input robIdxT i0, input excCodeT c0,
                              input robIdxT i1, input excCodeT c1);
        logic [31:0] r;
        @(posedge clk);
        r = nextRandom();
        dispEn <= en;
        dispEntry <= r[23:0];
        wbEn <= wb;
        wbIdx <= {i1, i0};
        wbExc <= {c1, c0};
    endtask

    task automatic waitDrain();
        int n;
        n = 0;
        while (mCount != 0 || mFlush) begin
            driveRandom(2'b00, 1'b1, 0);
            if (++n > 100) stop("buffer did not drain within 100 cycles");
        end
    endtask

    task automatic waitExc();
        int start;
        int n;
        start = excSeen;
        n = 0;
        while (excSeen == start) begin
            driveRandom(2'b00, 1'b0, 0);
            if (++n > 20) stop("no exception report within 20 cycles");
        end
    endtask

    initial begin
        int n;
        logic [31:0] r;
        dispEn = '0;
        dispEntry = '0;
        wbEn = '0;
        wbIdx = '0;
        wbExc = '0;
        n = 0;
        do begin
            @(negedge clk);
            if (++n > 20) stop("reset was never released");
        end while (rst);
        // mixed traffic
        for (int c = 0; c < 400; c++) begin
            r = nextRandom();
            driveRandom((r % 3 == 0) ? 2'b00 : (r % 3 == 1) ? 2'b01 : 2'b11, 1'b1, 12);
        end
        waitDrain();
        // fill up with no writeback
        repeat (12) driveRandom(2'b11, 1'b0, 0);
        expBase = mTail;
        repeat (3) driveRandom(2'b11, 1'b0, 0);
        @(negedge clk);
        if (full !== 1'b1 || allocIdx !== expBase) stop("buffer kept allocating when full");
        waitDrain();
        // fault in slot 1, slot 0 goes first
        expBase = mTail;
        driveFixed(2'b11, 2'b00, '0, '0, '0, '0);
        driveFixed(2'b00, 2'b11, expBase, 4'h0, expBase + 1'b1, 4'h3);
        waitExc();
        // fault at the head, then a clean entry after the flush
        expBase = mTail;
        driveFixed(2'b01, 2'b00, '0, '0, '0, '0);
        driveFixed(2'b00, 2'b01, expBase, 4'h9, '0, '0);
        waitExc();
        n = retired;
        @(negedge clk);
        if (allocIdx !== expBase + 1'b1) stop("allocation index moved on the flush");
        driveFixed(2'b01, 2'b00, '0, '0, '0, '0);
        driveFixed(2'b00, 2'b01, expBase + 1'b1, 4'h0, '0, '0);
        waitDrain();
        // retire outputs trail the model by one cycle
        @(posedge clk);
        if (retired == n) stop("entry after the flush did not retire");
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+verilog
verilog/robEntryPkg.sv
verilog/robEventPkg.sv
verilog/robIfs.sv
verilog/robPointers.sv
verilog/robEntryRam.sv
verilog/robStatus.sv
verilog/robRetire.sv
verilog/robTop.sv
test/robClock.sv
test/rob_assert.sv
test/robTb.sv
